/* project.f */
hw/dpc_pixel_pkg.sv
hw/dpc_frame_pkg.sv
hw/dpc_border_mirror.sv
hw/dpc_neighbor_sum.sv
hw/dpc_mean_divider.sv
hw/dpc_output_framer.sv
hw/dpc_corrector_top.sv
tests/dpc_properties.sv
tests/dpc_tb.sv

/* Makefile */
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module dpc_tb \
		-f project.f --Mdir $(BUILD_DIR) -o dpc_sim

run: compile
	./$(BUILD_DIR)/dpc_sim 2>&1 | tee $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "PASS: all tests" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/dpc_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dpc_tb
    import dpc_pixel_pkg::*;
();

    localparam int FRAME_WIDTH  = 8;
    localparam int FRAME_HEIGHT = 6;
    localparam int NUM_FRAMES   = 3;  // enable/centre-bad, all-bad/gaps, enable low
    localparam int LATENCY      = 7;
    localparam int NUM_BEATS    = NUM_FRAMES * FRAME_WIDTH * FRAME_HEIGHT;
    localparam int WATCHDOG_NS  = NUM_BEATS * 20 + 500;  // at most one idle cycle per beat

    typedef struct packed {
        pixel_t      data;
        logic        corrected;
        logic        tuser;
        logic        tlast;
        logic [31:0] due;  // cycle count when the beat must show
    } expect_t;

    logic      aclk = 1'b0;
    logic      aresetn;
    logic      s_tvalid;
    logic      s_tready;
    dpc_beat_t s_beat;
    logic      m_tready;
    logic      m_tvalid;
    pixel_t    m_tdata;
    logic      m_tuser;
    logic      m_tlast;
    logic      m_corrected;

    integer      seed;
    logic [31:0] cycle = '0;
    int          value_errs = 0;
    int          other_errs = 0;
    int          checked = 0;
    expect_t     exp_q[$];
    expect_t     head;

    always #5 aclk = ~aclk;

    always @(posedge aclk) cycle <= cycle + 1;

    dpc_corrector_top #(
        .FRAME_WIDTH  (FRAME_WIDTH),
        .FRAME_HEIGHT (FRAME_HEIGHT)
    ) dut_i (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .s_tvalid    (s_tvalid),
        .s_tready    (s_tready),
        .s_beat      (s_beat),
        .m_tready    (m_tready),
        .m_tvalid    (m_tvalid),
        .m_tdata     (m_tdata),
        .m_tuser     (m_tuser),
        .m_tlast     (m_tlast),
        .m_corrected (m_corrected)
    );

    // ==========================================================================
    // stimulus and reference model
    // ==========================================================================
    function automatic dpc_beat_t random_beat(input int phase);
        dpc_beat_t               b;
        logic [8:0][PIXEL_W-1:0] px;
        logic [8:0]              g;
        for (int k = 0; k < 9; k++) begin
            px[k] = PIXEL_W'($random(seed));
            g[k]  = (phase == 0) ? (($random(seed) & 3) != 0) : (($random(seed) & 1) != 0);
        end
        if (phase == 1 && ($random(seed) & 3) == 0)
            g = '0;                      // no good neighbour at all
        if (phase == 0)
            g[4] = ($random(seed) & 1) != 0;
        else if (phase == 1)
            g[4] = 1'b0;
        b.win    = px;
        b.mask   = g;
        b.enable = (phase != 2);
        return b;
    endfunction

    // window position (r, c) sits at packed index 8 - 3r - c
    task automatic predict(input dpc_beat_t b, input int col, input int row);
        logic [8:0][PIXEL_W-1:0] px;
        logic [8:0]              g;
        int                      sum;
        int                      cnt;
        expect_t                 e;
        px  = b.win;
        g   = b.mask;
        sum = 0;
        cnt = 0;
        for (int r = 0; r < 3; r++) begin
            if (col == 0) begin
                px[8-3*r] = px[6-3*r];
                g[8-3*r]  = g[6-3*r];
            end else if (col == FRAME_WIDTH - 1) begin
                px[6-3*r] = px[8-3*r];
                g[6-3*r]  = g[8-3*r];
            end
        end
        for (int c = 0; c < 3; c++) begin
            if (row == 0) begin
                px[8-c] = px[2-c];
                g[8-c]  = g[2-c];
            end else if (row == FRAME_HEIGHT - 1) begin
                px[2-c] = px[8-c];
                g[2-c]  = g[8-c];
            end
        end
        for (int k = 0; k < 9; k++) begin
            if (k != 4 && g[k]) begin
                sum += int'(px[k]);
                cnt++;
            end
        end
        e.corrected = !g[4] && b.enable;
        e.data      = (e.corrected && cnt > 0) ? PIXEL_W'(sum / cnt) : px[4];
        e.tuser     = (col == 0) && (row == 0);
        e.tlast     = (col == FRAME_WIDTH - 1);
        e.due       = cycle + LATENCY;  // accepted at the coming edge
        exp_q.push_back(e);
    endtask

    task automatic send_frame(input int phase);
        logic gap;
        for (int row = 0; row < FRAME_HEIGHT; row++) begin
            for (int col = 0; col < FRAME_WIDTH; col++) begin
                case (phase)
                    1:       gap = ($random(seed) & 1) != 0;
                    2:       gap = ($random(seed) & 3) == 0;
                    default: gap = 1'b0;
                endcase
                if (gap) begin
                    @(posedge aclk);
                    #1;
                end
                s_beat   = random_beat(phase);
                s_tvalid = 1'b1;
                predict(s_beat, col, row);
                @(posedge aclk);
                #1;
                s_tvalid = 1'b0;
            end
        end
    endtask

    // ==========================================================================
    // checking
    // ==========================================================================
    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            value_errs++;
            $display("FAILED at %0t: %s expected %0h, got %0h", $time, name, exp, got);
        end
    endtask

    always @(negedge aclk) begin
        check_value("s_tready", 32'(m_tready), 32'(s_tready));  // ready passes straight through
        if (!aresetn) begin
            assert (!m_tvalid && !m_tuser && !m_tlast && !m_corrected) else begin
                other_errs++;
                $display("outputs active during reset at %0t", $time);
            end
        end else if (m_tvalid) begin
            assert (exp_q.size() != 0) else begin
                other_errs++;
                $display("output beat at %0t with no beat expected", $time);
            end
            if (exp_q.size() != 0) begin
                head = exp_q.pop_front();
                checked++;
                check_value("m_tdata", 32'(head.data), 32'(m_tdata));
                check_value("m_corrected", 32'(head.corrected), 32'(m_corrected));
                check_value("m_tuser", 32'(head.tuser), 32'(m_tuser));
                check_value("m_tlast", 32'(head.tlast), 32'(m_tlast));
                check_value("latency cycle", head.due, cycle);
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout after %0d ns, %0d beats never came out", WATCHDOG_NS, exp_q.size());
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        seed     = 20;
        aresetn  = 1'b0;
        s_tvalid = 1'b0;
        s_beat   = '0;
        m_tready = 1'b1;
        repeat (8) @(posedge aclk);
        #1;
        aresetn = 1'b1;
        for (int f = 0; f < NUM_FRAMES; f++)
            send_frame(f);
        while (exp_q.size() != 0)
            @(negedge aclk);
        repeat (2) @(posedge aclk);
        $display("checked %0d beats: %0d value errors, %0d other errors",
                 checked, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0 && checked == NUM_BEATS)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/dpc_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module dpc_properties #(
    parameter int LATENCY = 7  // mirror 2, sum 1, divider 4
) (
    input logic aclk,
    input logic aresetn,
    input logic s_tvalid,
    input logic s_tready,
    input logic m_tvalid,
    input logic m_tlast
);

    // ==========================================================================
    // stream timing
    // ==========================================================================
    property p_latency;
        @(posedge aclk) disable iff (!aresetn)
            (s_tvalid && s_tready) |-> ##LATENCY m_tvalid;
    endproperty

    property p_last_needs_valid;
        @(posedge aclk) m_tlast |-> m_tvalid;
    endproperty

    property p_quiet_in_reset;
        @(posedge aclk) !aresetn |-> !m_tvalid;
    endproperty

    a_latency : assert property (p_latency)
        else $error("accepted beat missing at the output %0d cycles later", LATENCY);
    a_last : assert property (p_last_needs_valid)
        else $error("m_tlast high without m_tvalid");
    a_reset : assert property (p_quiet_in_reset)
        else $error("m_tvalid high during reset");

endmodule

bind dpc_corrector_top dpc_properties props_i (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .s_tvalid (s_tvalid),
    .s_tready (s_tready),
    .m_tvalid (m_tvalid),
    .m_tlast  (m_tlast)
);

`default_nettype wire

/* hw/dpc_corrector_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dpc_corrector_top
    import dpc_pixel_pkg::*, dpc_frame_pkg::*;
#(
    parameter int FRAME_WIDTH  = DEF_FRAME_WIDTH,
    parameter int FRAME_HEIGHT = DEF_FRAME_HEIGHT,
    parameter int DIV_STAGES   = 4
) (
    input  logic      aclk,
    input  logic      aresetn,
    input  logic      s_tvalid,
    output logic      s_tready,
    input  dpc_beat_t s_beat,
    input  logic      m_tready,
    output logic      m_tvalid,
    output pixel_t    m_tdata,
    output logic      m_tuser,
    output logic      m_tlast,
    output logic      m_corrected
);

    logic        beat_accept;
    logic        mir_valid;
    dpc_beat_t   mir_beat;
    logic        sum_valid;
    dpc_sum_t    sum_data;
    logic        div_valid;
    dpc_result_t div_result;

    // no stall inside, ready comes straight from the sink
    assign s_tready    = m_tready;
    assign beat_accept = s_tvalid && s_tready;

    dpc_border_mirror #(
        .FRAME_WIDTH  (FRAME_WIDTH),
        .FRAME_HEIGHT (FRAME_HEIGHT)
    ) mirror_i (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .in_valid  (beat_accept),
        .in_beat   (s_beat),
        .out_valid (mir_valid),
        .out_beat  (mir_beat)
    );

    dpc_neighbor_sum sum_i (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .in_valid  (mir_valid),
        .in_beat   (mir_beat),
        .out_valid (sum_valid),
        .out_sum   (sum_data)
    );

    dpc_mean_divider #(
        .DIV_STAGES (DIV_STAGES)
    ) div_i (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .in_valid   (sum_valid),
        .in_sum     (sum_data),
        .out_valid  (div_valid),
        .out_result (div_result)
    );

    dpc_output_framer #(
        .FRAME_WIDTH  (FRAME_WIDTH),
        .FRAME_HEIGHT (FRAME_HEIGHT)
    ) framer_i (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .in_valid    (div_valid),
        .in_result   (div_result),
        .m_tvalid    (m_tvalid),
        .m_tuser     (m_tuser),
        .m_tlast     (m_tlast),
        .m_corrected (m_corrected),
        .m_tdata     (m_tdata)
    );

endmodule

`default_nettype wire

/* hw/dpc_output_framer.sv */
`timescale 1ns/1ps
`default_nettype none

module dpc_output_framer
    import dpc_pixel_pkg::*, dpc_frame_pkg::*;
#(
    parameter int FRAME_WIDTH  = DEF_FRAME_WIDTH,
    parameter int FRAME_HEIGHT = DEF_FRAME_HEIGHT
) (
    input  logic        aclk,
    input  logic        aresetn,
    input  logic        in_valid,
    input  dpc_result_t in_result,
    output logic        m_tvalid,
    output logic        m_tuser,
    output logic        m_tlast,
    output logic        m_corrected,
    output pixel_t      m_tdata
);

    logic [COORD_W-1:0] col_out;
    logic [COORD_W-1:0] row_out;
    logic               eol;
    logic               eof;

    assign eol = (col_out == COORD_W'(FRAME_WIDTH - 1));
    assign eof = (row_out == COORD_W'(FRAME_HEIGHT - 1));

    // ==========================================================================
    // output coordinates, one step per output beat
    // ==========================================================================
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            col_out <= '0;
            row_out <= '0;
        end else if (in_valid) begin
            if (eol) begin
                col_out <= '0;
                row_out <= eof ? '0 : row_out + 1'b1;
            end else begin
                col_out <= col_out + 1'b1;
            end
        end
    end

    assign m_tvalid    = in_valid;
    assign m_tdata     = in_result.use_mean ? in_result.mean : in_result.original;
    assign m_tuser     = in_valid && (col_out == '0) && (row_out == '0);  // sof
    assign m_tlast     = in_valid && eol;
    assign m_corrected = in_valid && in_result.corrected;

endmodule

`default_nettype wire

/* hw/dpc_mean_divider.sv */
`timescale 1ns/1ps
`default_nettype none

module dpc_mean_divider
    import dpc_pixel_pkg::*;
#(
    parameter int DIV_STAGES = 4
) (
    input  logic        aclk,
    input  logic        aresetn,
    input  logic        in_valid,
    input  dpc_sum_t    in_sum,
    output logic        out_valid,
    output dpc_result_t out_result
);

    localparam int STEP  = (SUM_W + DIV_STAGES - 1) / DIV_STAGES;  // quotient bits per stage
    localparam int NUM_W = STEP * DIV_STAGES;

    typedef struct packed {
        logic [NUM_W-1:0] num;   // dividend shifts out at msb, quotient fills lsb
        logic [CNT_W-1:0] rem;   // stays below den, so < 8
        logic [CNT_W-1:0] den;
        pixel_t           original;
        logic             correct_req;
        logic             corrected;
    } div_stage_t;

    div_stage_t        st  [DIV_STAGES+1];
    logic [DIV_STAGES:0] vld;

    // STEP iterations of shift, trial subtract, restore
    function automatic div_stage_t div_step(input div_stage_t s);
        div_stage_t r;
        r = s;
        for (int i = 0; i < STEP; i++) begin
            r.rem = {r.rem[CNT_W-2:0], r.num[NUM_W-1]};
            r.num = {r.num[NUM_W-2:0], 1'b0};
            if (r.rem >= r.den) begin
                r.rem    = r.rem - r.den;
                r.num[0] = 1'b1;
            end
        end
        return r;
    endfunction

    assign vld[0]            = in_valid;
    assign st[0].num         = NUM_W'(in_sum.sum);
    assign st[0].rem         = '0;
    assign st[0].den         = in_sum.count;
    assign st[0].original    = in_sum.centre;
    assign st[0].correct_req = in_sum.correct_req;
    assign st[0].corrected   = in_sum.corrected;

    for (genvar k = 0; k < DIV_STAGES; k++) begin : g_stage
        always_ff @(posedge aclk) begin
            st[k+1] <= div_step(st[k]);
        end

        always_ff @(posedge aclk or negedge aresetn) begin
            if (!aresetn) vld[k+1] <= 1'b0;
            else          vld[k+1] <= vld[k];
        end
    end

    // floor mean of good neighbours never exceeds a pixel
    assign out_valid           = vld[DIV_STAGES];
    assign out_result.mean     = st[DIV_STAGES].num[PIXEL_W-1:0];
    assign out_result.original = st[DIV_STAGES].original;
    assign out_result.use_mean = st[DIV_STAGES].correct_req && (st[DIV_STAGES].den != '0);
    assign out_result.corrected = st[DIV_STAGES].corrected;

endmodule

`default_nettype wire

/* hw/dpc_neighbor_sum.sv */
`timescale 1ns/1ps
`default_nettype none

module dpc_neighbor_sum
    import dpc_pixel_pkg::*;
(
    input  logic      aclk,
    input  logic      aresetn,
    input  logic      in_valid,
    input  dpc_beat_t in_beat,
    output logic      out_valid,
    output dpc_sum_t  out_sum
);

    pixel_t           nb [8];  // neighbours, centre left out
    logic [7:0]       good;
    logic [SUM_W-1:0] sum_c;
    logic [CNT_W-1:0] cnt_c;
    logic             centre_bad;

    assign nb = '{in_beat.win.w11, in_beat.win.w12, in_beat.win.w13, in_beat.win.w21,
                  in_beat.win.w23, in_beat.win.w31, in_beat.win.w32, in_beat.win.w33};

    assign good = {in_beat.mask.g33, in_beat.mask.g32, in_beat.mask.g31, in_beat.mask.g23,
                   in_beat.mask.g21, in_beat.mask.g13, in_beat.mask.g12, in_beat.mask.g11};

    assign centre_bad = !in_beat.mask.g22;

    // masked adder tree
    always_comb begin
        sum_c = '0;
        cnt_c = '0;
        for (int i = 0; i < 8; i++) begin
            if (good[i]) begin
                sum_c = sum_c + SUM_W'(nb[i]);
                cnt_c = cnt_c + 1'b1;
            end
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) out_valid <= 1'b0;
        else          out_valid <= in_valid;
    end

    always_ff @(posedge aclk) begin
        out_sum.sum         <= sum_c;
        out_sum.count       <= cnt_c;
        out_sum.centre      <= in_beat.win.w22;
        out_sum.correct_req <= centre_bad && in_beat.enable;
        out_sum.corrected   <= centre_bad && in_beat.enable;
    end

endmodule

`default_nettype wire

/* hw/dpc_border_mirror.sv */
`timescale 1ns/1ps
`default_nettype none

module dpc_border_mirror
    import dpc_pixel_pkg::*, dpc_frame_pkg::*;
#(
    parameter int FRAME_WIDTH  = DEF_FRAME_WIDTH,
    parameter int FRAME_HEIGHT = DEF_FRAME_HEIGHT
) (
    input  logic      aclk,
    input  logic      aresetn,
    input  logic      in_valid,
    input  dpc_beat_t in_beat,
    output logic      out_valid,
    output dpc_beat_t out_beat
);

    logic [COORD_W-1:0] col_cnt;
    logic [COORD_W-1:0] row_cnt;
    dpc_edge_t          pos;

    dpc_beat_t col_beat;     // column mirror, comb
    dpc_beat_t stg1_beat;
    logic      stg1_valid;
    logic      first_row_q;  // row flags aligned with stg1
    logic      last_row_q;
    dpc_beat_t row_beat;

    // ==========================================================================
    // input coordinates
    // ==========================================================================
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (in_valid) begin
            if (pos.last_col) begin
                col_cnt <= '0;
                row_cnt <= pos.last_row ? '0 : row_cnt + 1'b1;
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    assign pos.first_col = (col_cnt == '0);
    assign pos.last_col  = (col_cnt == COORD_W'(FRAME_WIDTH - 1));
    assign pos.first_row = (row_cnt == '0);
    assign pos.last_row  = (row_cnt == COORD_W'(FRAME_HEIGHT - 1));

    // ==========================================================================
    // step 1: columns
    // ==========================================================================
    always_comb begin
        col_beat = in_beat;
        if (pos.first_col) begin  // left <- right
            col_beat.win.w11  = in_beat.win.w13;
            col_beat.win.w21  = in_beat.win.w23;
            col_beat.win.w31  = in_beat.win.w33;
            col_beat.mask.g11 = in_beat.mask.g13;
            col_beat.mask.g21 = in_beat.mask.g23;
            col_beat.mask.g31 = in_beat.mask.g33;
        end
        if (pos.last_col) begin   // right <- left
            col_beat.win.w13  = in_beat.win.w11;
            col_beat.win.w23  = in_beat.win.w21;
            col_beat.win.w33  = in_beat.win.w31;
            col_beat.mask.g13 = in_beat.mask.g11;
            col_beat.mask.g23 = in_beat.mask.g21;
            col_beat.mask.g33 = in_beat.mask.g31;
        end
    end

    // ==========================================================================
    // step 2: rows
    // ==========================================================================
    always_comb begin
        row_beat = stg1_beat;
        if (first_row_q) begin  // top <- bottom
            row_beat.win.w11  = stg1_beat.win.w31;
            row_beat.win.w12  = stg1_beat.win.w32;
            row_beat.win.w13  = stg1_beat.win.w33;
            row_beat.mask.g11 = stg1_beat.mask.g31;
            row_beat.mask.g12 = stg1_beat.mask.g32;
            row_beat.mask.g13 = stg1_beat.mask.g33;
        end
        if (last_row_q) begin   // bottom <- top
            row_beat.win.w31  = stg1_beat.win.w11;
            row_beat.win.w32  = stg1_beat.win.w12;
            row_beat.win.w33  = stg1_beat.win.w13;
            row_beat.mask.g31 = stg1_beat.mask.g11;
            row_beat.mask.g32 = stg1_beat.mask.g12;
            row_beat.mask.g33 = stg1_beat.mask.g13;
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            stg1_valid  <= 1'b0;
            first_row_q <= 1'b0;
            last_row_q  <= 1'b0;
            out_valid   <= 1'b0;
        end else begin
            stg1_valid  <= in_valid;
            first_row_q <= pos.first_row;
            last_row_q  <= pos.last_row;
            out_valid   <= stg1_valid;
        end
    end

    always_ff @(posedge aclk) begin
        stg1_beat <= col_beat;
        out_beat  <= row_beat;
    end

endmodule

`default_nettype wire

/* hw/dpc_frame_pkg.sv */
`default_nettype none

package dpc_frame_pkg;

    localparam int COORD_W = 10;

    // default sensor geometry
    localparam int DEF_FRAME_WIDTH  = 640;
    localparam int DEF_FRAME_HEIGHT = 512;

    // position of a beat relative to the frame border
    typedef struct packed {
        logic first_col;
        logic last_col;
        logic first_row;
        logic last_row;
    } dpc_edge_t;

endpackage

`default_nettype wire

/* hw/dpc_pixel_pkg.sv */
`default_nettype none

package dpc_pixel_pkg;

    localparam int PIXEL_W = 16;
    localparam int SUM_W   = PIXEL_W + 3;  // eight pixels summed
    localparam int CNT_W   = 4;            // 0..8 good neighbours

    typedef logic [PIXEL_W-1:0] pixel_t;

    // ==========================================================================
    // 3x3 window, row-major, w22 is the centre
    // ==========================================================================
    typedef struct packed {
        pixel_t w11, w12, w13;
        pixel_t w21, w22, w23;
        pixel_t w31, w32, w33;
    } dpc_window_t;

    // 1 = good pixel, same positions as the window
    typedef struct packed {
        logic g11, g12, g13;
        logic g21, g22, g23;
        logic g31, g32, g33;
    } dpc_mask_t;

    typedef struct packed {
        dpc_window_t win;
        dpc_mask_t   mask;
        logic        enable;  // correction enable sampled with the beat
    } dpc_beat_t;

    typedef struct packed {
        logic [SUM_W-1:0] sum;          // good neighbours only
        logic [CNT_W-1:0] count;
        pixel_t           centre;
        logic             correct_req;  // centre bad, enable set
        logic             corrected;
    } dpc_sum_t;

    typedef struct packed {
        pixel_t mean;
        pixel_t original;
        logic   use_mean;
        logic   corrected;
    } dpc_result_t;

endpackage

`default_nettype wire
